// File: all.f
src/lcd_pkg.sv
src/lcd_pixel_buffer.sv
src/lcd_frame_sequencer.sv
src/lcd_bus_driver.sv
src/lcd_writer_top.sv
verif/lcd_bus_monitor.sv
verif/lcd_writer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LCD writer testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lcd_writer_tb -f all.f -o lcd_sim &&
  ./obj_dir/lcd_sim 2>&1 | tee sim.log &&
  ! grep -q ">>> FAIL" sim.log ||
  { echo "Simulation failed, see sim.log"; exit 1; }

echo "Simulation passed"

// File: src/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver import lcd_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // From the sequencer
  input  logic       i_item_valid,
  input  bus_item_t  i_item,
  output logic       o_bus_credit,

  // Panel bus
  output logic [7:0] o_data,
  output logic       o_cmd_mode,
  output logic       o_write,
  output logic       o_data_out_en
);

  typedef logic [$clog2(BUS_QUEUE_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(BUS_QUEUE_DEPTH+1)-1:0] cnt_t;

  bus_item_t queue [BUS_QUEUE_DEPTH];
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  cnt_t      count;
  bus_item_t head;
  logic      strobe_phase;
  logic      do_pop;

  assign head = queue[rd_ptr];

  // Entry leaves the queue in the falling phase of its strobe
  assign do_pop = strobe_phase;

  always_ff @(posedge clk) begin
    if (i_item_valid) begin
      queue[wr_ptr] <= i_item;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_item_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_item_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Panel data lines, held from strobe rise until the next byte
  always_ff @(posedge clk) begin
    if (!strobe_phase && (count != '0)) begin
      o_data <= head.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strobe_phase  <= 1'b0;
      o_write       <= 1'b0;
      o_cmd_mode    <= 1'b1;
      o_bus_credit  <= 1'b0;
      o_data_out_en <= 1'b0;
    end else begin
      o_bus_credit <= 1'b0;
      if (strobe_phase) begin
        // Falling phase
        o_write      <= 1'b0;
        o_bus_credit <= 1'b1;
        strobe_phase <= 1'b0;
      end else if (count != '0) begin
        // Rising phase, cmd_mode is low for a command byte
        o_cmd_mode    <= !head.is_cmd;
        o_write       <= 1'b1;
        o_data_out_en <= 1'b1;
        strobe_phase  <= 1'b1;
      end
    end
  end

endmodule

// File: src/lcd_frame_sequencer.sv
`timescale 1ns/1ps

module lcd_frame_sequencer import lcd_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  // Control
  input  logic                   i_enable,
  input  logic [PIX_COUNT_W-1:0] i_num_pixels,
  input  logic                   i_tearing_effect,

  // Pixel buffer
  input  logic                   i_not_empty,
  input  pixel_word_t            i_head,
  output logic                   o_pop,

  // Bus driver
  input  logic                   i_bus_credit,
  output logic                   o_item_valid,
  output bus_item_t              o_item,

  output logic                   o_frame_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_RED,
    ST_GREEN,
    ST_BLUE
  } state_t;

  typedef logic [$clog2(BUS_QUEUE_DEPTH+1)-1:0] credit_t;

  state_t                 state;
  credit_t                credit_cnt;
  logic [PIX_COUNT_W-1:0] pix_cnt;
  logic [PIX_COUNT_W-1:0] num_pixels;
  logic                   has_credit;
  logic                   send;
  logic                   last_pixel;

  assign has_credit = (credit_cnt != '0);
  assign last_pixel = ((pix_cnt + 1'b1) == num_pixels);

  // An item goes out only with a free credit, pixel bytes also need a word
  always_comb begin
    case (state)
      ST_CMD:                     send = has_credit;
      ST_RED, ST_GREEN, ST_BLUE:  send = has_credit && i_not_empty;
      default:                    send = 1'b0;
    endcase
  end

  always_comb begin
    o_item.is_cmd = 1'b0;
    case (state)
      ST_CMD: begin
        o_item.is_cmd = 1'b1;
        o_item.value  = CMD_MEM_WRITE;
      end
      ST_RED:   o_item.value = i_head.red;
      ST_GREEN: o_item.value = i_head.green;
      default:  o_item.value = i_head.blue;
    endcase
  end

  assign o_item_valid = send;

  // Word leaves the buffer together with its blue byte
  assign o_pop        = send && (state == ST_BLUE);
  assign o_frame_done = o_pop && last_pixel;

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= credit_t'(BUS_QUEUE_DEPTH);
    end else begin
      case ({i_bus_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      pix_cnt    <= '0;
      num_pixels <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Enable only matters here, a started frame runs to the end
          if (i_enable && i_tearing_effect && i_not_empty && (i_num_pixels != '0)) begin
            num_pixels <= i_num_pixels;
            pix_cnt    <= '0;
            state      <= ST_CMD;
          end
        end
        ST_CMD: begin
          if (send) begin
            state <= ST_RED;
          end
        end
        ST_RED: begin
          if (send) begin
            state <= ST_GREEN;
          end
        end
        ST_GREEN: begin
          if (send) begin
            state <= ST_BLUE;
          end
        end
        ST_BLUE: begin
          if (send) begin
            pix_cnt <= pix_cnt + 1'b1;
            if (last_pixel) begin
              state <= ST_IDLE;
            end else begin
              state <= ST_RED;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: src/lcd_pixel_buffer.sv
`timescale 1ns/1ps

module lcd_pixel_buffer import lcd_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // Upstream side
  input  logic        i_pix_valid,
  input  pixel_word_t i_pix_data,
  output logic        o_pix_credit,

  // Sequencer side, show-ahead
  input  logic        i_pop,
  output logic        o_not_empty,
  output pixel_word_t o_head
);

  pixel_word_t          mem [PIX_DEPTH];
  logic [PIX_PTR_W-1:0] wr_ptr;
  logic [PIX_PTR_W-1:0] rd_ptr;
  logic [PIX_PTR_W:0]   count;
  logic                 do_pop;

  assign o_not_empty = (count != '0);
  assign o_head      = mem[rd_ptr];

  // Ignore a pop strobe on an empty buffer
  assign do_pop = i_pop && o_not_empty;

  // Storage, no reset
  always_ff @(posedge clk) begin
    if (i_pix_valid) begin
      mem[wr_ptr] <= i_pix_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      o_pix_credit <= 1'b0;
    end else begin
      if (i_pix_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({i_pix_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // One credit back upstream per word taken
      o_pix_credit <= do_pop;
    end
  end

endmodule

// File: src/lcd_pkg.sv
package lcd_pkg;

  // Pixel buffer sizing, also the upstream credit count at reset
  localparam int PIX_DEPTH = 16;
  localparam int PIX_PTR_W = 4;

  // Entries in the bus driver queue, also the sequencer credits at reset
  localparam int BUS_QUEUE_DEPTH = 2;

  // Width of the programmed pixel count
  localparam int PIX_COUNT_W = 24;

  // Panel memory-write command
  localparam logic [7:0] CMD_MEM_WRITE = 8'h2C;

  // One upstream pixel word, low byte unused
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [7:0] pad;
  } pixel_word_t;

  // One byte for the panel bus
  typedef struct packed {
    logic       is_cmd;
    logic [7:0] value;
  } bus_item_t;

endpackage

// File: src/lcd_writer_top.sv
`timescale 1ns/1ps

module lcd_writer_top import lcd_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  // Control
  input  logic                   i_enable,
  input  logic [PIX_COUNT_W-1:0] i_num_pixels,
  input  logic                   i_tearing_effect,

  // Upstream pixel stream
  input  logic                   i_pix_valid,
  input  pixel_word_t            i_pix_data,
  output logic                   o_pix_credit,

  output logic                   o_frame_done,

  // Panel bus
  output logic [7:0]             o_data,
  output logic                   o_cmd_mode,
  output logic                   o_write,
  output logic                   o_data_out_en
);

  logic        pix_not_empty;
  pixel_word_t pix_head;
  logic        pix_pop;
  logic        item_valid;
  bus_item_t   item;
  logic        bus_credit;

  lcd_pixel_buffer pix_buf0 (
    .clk          (clk),
    .rst          (rst),
    .i_pix_valid  (i_pix_valid),
    .i_pix_data   (i_pix_data),
    .i_pop        (pix_pop),
    .o_not_empty  (pix_not_empty),
    .o_head       (pix_head),
    .o_pix_credit (o_pix_credit)
  );

  lcd_frame_sequencer seq0 (
    .clk              (clk),
    .rst              (rst),
    .i_enable         (i_enable),
    .i_num_pixels     (i_num_pixels),
    .i_tearing_effect (i_tearing_effect),
    .i_not_empty      (pix_not_empty),
    .i_head           (pix_head),
    .i_bus_credit     (bus_credit),
    .o_pop            (pix_pop),
    .o_item_valid     (item_valid),
    .o_item           (item),
    .o_frame_done     (o_frame_done)
  );

  lcd_bus_driver drv0 (
    .clk           (clk),
    .rst           (rst),
    .i_item_valid  (item_valid),
    .i_item        (item),
    .o_bus_credit  (bus_credit),
    .o_data        (o_data),
    .o_cmd_mode    (o_cmd_mode),
    .o_write       (o_write),
    .o_data_out_en (o_data_out_en)
  );

endmodule

// File: verif/lcd_bus_monitor.sv
`timescale 1ns/1ps

module lcd_bus_monitor import lcd_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [95:0]            i_test_name,
  input  logic                   i_final_check,
  input  int                     i_expected_frames,
  // Watched DUT ports
  input  logic                   i_enable,
  input  logic [PIX_COUNT_W-1:0] i_num_pixels,
  input  logic                   i_tearing_effect,
  input  logic                   i_pix_valid,
  input  pixel_word_t            i_pix_data,
  input  logic                   i_pix_credit,
  input  logic                   i_frame_done,
  input  logic [7:0]             i_data,
  input  logic                   i_cmd_mode,
  input  logic                   i_write,
  input  logic                   i_data_out_en,
  output logic                   o_busy,
  output int                     o_value_errors,
  output int                     o_other_errors
);

  // Words accepted upstream in arrival order
  pixel_word_t words [$];
  int          bytes_left = 0;
  int          color_idx = 0;
  int          frames_started = 0;
  int          done_count = 0;
  int          word_count = 0;
  int          credit_count = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  bit          te_seen = 1'b0;
  bit          rst_d = 1'b0;
  bit          wrote_once = 1'b0;
  bit          write_d = 1'b0;

  assign o_busy         = (bytes_left != 0);
  assign o_value_errors = value_errs;
  assign o_other_errors = other_errs;

  task automatic check_byte_value(input string what, input logic [7:0] exp,
                                  input logic [7:0] act);
    if (exp !== act) begin
      $display("Fail %0s: %0s expected 0x%02h actual 0x%02h", i_test_name, what, exp, act);
      value_errs++;
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("Fail %0s: %0s expected %0d actual %0d", i_test_name, what, exp, act);
      value_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error in %0s at %0t: %0s", i_test_name, $time, msg);
    other_errs++;
  endtask

  // Predict one strobed byte from the command and the red, green and blue of each word
  task automatic predict_bus_byte();
    pixel_word_t w;
    logic [7:0]  exp;
    string       what;
    if (bytes_left == 0) begin
      if (!te_seen) report_error("frame started without tearing effect while enabled");
      if (done_count != frames_started) begin
        report_error("frame started before the last one was done");
      end
      check_byte_value("command mode", 8'h00, {7'b0, i_cmd_mode});
      check_byte_value("command byte", CMD_MEM_WRITE, i_data);
      te_seen        = 1'b0;
      frames_started++;
      bytes_left     = 3 * int'(i_num_pixels);
      color_idx      = 0;
    end else begin
      check_byte_value("data mode", 8'h01, {7'b0, i_cmd_mode});
      if (words.size() == 0) begin
        report_error("data byte on the bus with no accepted pixel word");
      end else begin
        w = words[0];
        case (color_idx)
          0: begin
            exp  = w.red;
            what = "red byte";
          end
          1: begin
            exp  = w.green;
            what = "green byte";
          end
          default: begin
            exp  = w.blue;
            what = "blue byte";
          end
        endcase
        check_byte_value(what, exp, i_data);
        if (color_idx == 2) void'(words.pop_front());
      end
      color_idx  = (color_idx + 1) % 3;
      bytes_left--;
    end
  endtask

  always @(posedge clk) begin
    if (rst_d && ({i_write, i_data_out_en, i_pix_credit, i_frame_done, i_cmd_mode}
                  !== 5'b00001)) begin
      report_error("outputs not at their reset values");
    end
    rst_d = rst;
    if (!rst) begin
      if (i_enable && i_tearing_effect) te_seen = 1'b1;
      if (i_pix_valid) begin
        words.push_back(i_pix_data);
        word_count++;
      end
      if (i_pix_credit) credit_count++;
      if (i_frame_done) begin
        done_count++;
        if (done_count != frames_started) report_error("o_frame_done pulse with no frame open");
      end
      if (i_data_out_en !== (wrote_once || i_write)) begin
        report_error("o_data_out_en wrong for this point");
      end
      if (i_write && write_d) report_error("o_write high for two cycles in a row");
      if (i_write) begin
        predict_bus_byte();
        wrote_once = 1'b1;
      end
      write_d = i_write;
      if (i_final_check) begin
        if (bytes_left != 0) report_error("last frame ended with bytes missing");
        if (words.size() != 0) report_error("accepted words never reached the bus");
        compare_count("pixel credits", word_count, credit_count);
        compare_count("frames started", i_expected_frames, frames_started);
        compare_count("frame_done pulses", frames_started, done_count);
      end
    end
  end

endmodule

// File: verif/lcd_writer_tb.sv
`timescale 1ns/1ps

module lcd_writer_tb import lcd_pkg::*; ();

  typedef struct packed {
    logic [95:0] name;
    int          num_pixels;
    int          te_delay;
    int          pause;
  } frame_row_t;

  typedef enum {WAIT_WRITE, WAIT_DONE, WAIT_IDLE} wait_kind_t;

  // Name, pixels, cycles before tearing effect, upstream pause between words
  frame_row_t frame_table [6] = '{
    '{"single_pixel", 1, 2, 0},
    '{"short_frame", 5, 4, 1},
    '{"fill_buffer", 16, 12, 0},
    '{"over_depth", 40, 6, 0},
    '{"long_pause", 6, 3, 25},
    '{"mixed_pause", 24, 20, 3}
  };

  logic                   clk;
  logic                   rst;
  logic                   i_enable;
  logic [PIX_COUNT_W-1:0] i_num_pixels;
  logic                   i_tearing_effect;
  logic                   i_pix_valid;
  pixel_word_t            i_pix_data;
  logic                   o_pix_credit;
  logic                   o_frame_done;
  logic [7:0]             o_data;
  logic                   o_cmd_mode;
  logic                   o_write;
  logic                   o_data_out_en;
  logic                   final_check;
  logic [95:0]            cur_name;
  logic                   mon_busy;
  int                     value_errors;
  int                     other_errors;
  int                     frames_run;
  int                     credits;
  int                     timeouts;
  int                     row;
  bit                     aborted;

  lcd_writer_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .i_enable         (i_enable),
    .i_num_pixels     (i_num_pixels),
    .i_tearing_effect (i_tearing_effect),
    .i_pix_valid      (i_pix_valid),
    .i_pix_data       (i_pix_data),
    .o_pix_credit     (o_pix_credit),
    .o_frame_done     (o_frame_done),
    .o_data           (o_data),
    .o_cmd_mode       (o_cmd_mode),
    .o_write          (o_write),
    .o_data_out_en    (o_data_out_en)
  );

  lcd_bus_monitor lcd_bus_monitor (
    .clk               (clk),
    .rst               (rst),
    .i_test_name       (cur_name),
    .i_final_check     (final_check),
    .i_expected_frames (frames_run),
    .i_enable          (i_enable),
    .i_num_pixels      (i_num_pixels),
    .i_tearing_effect  (i_tearing_effect),
    .i_pix_valid       (i_pix_valid),
    .i_pix_data        (i_pix_data),
    .i_pix_credit      (o_pix_credit),
    .i_frame_done      (o_frame_done),
    .i_data            (o_data),
    .i_cmd_mode        (o_cmd_mode),
    .i_write           (o_write),
    .i_data_out_en     (o_data_out_en),
    .o_busy            (mon_busy),
    .o_value_errors    (value_errors),
    .o_other_errors    (other_errors)
  );

  always #10 clk = ~clk;

  // One upstream credit spent per valid and one back per credit pulse
  always @(posedge clk) begin
    if (rst) begin
      credits <= PIX_DEPTH;
    end else if (i_pix_valid && !o_pix_credit) begin
      credits <= credits - 1;
    end else if (!i_pix_valid && o_pix_credit) begin
      credits <= credits + 1;
    end
  end

  // Checks 1 ns after each edge until the condition holds
  task automatic wait_until(input wait_kind_t kind, input string what);
    bit hit;
    int n;
    hit = 1'b0;
    for (n = 0; n < 2000 && !hit && !aborted; n++) begin
      @(posedge clk);
      #1;
      case (kind)
        WAIT_WRITE: hit = o_write;
        WAIT_DONE:  hit = o_frame_done;
        default:    hit = !mon_busy;
      endcase
    end
    if (!hit && !aborted) begin
      $display("Error in %0s: timed out waiting for %0s", cur_name, what);
      timeouts++;
      aborted = 1'b1;
    end
  endtask

  task automatic send_words(input int count, input int pause);
    int sent;
    int n;
    for (sent = 0; sent < count && !aborted; sent++) begin
      for (n = 0; credits == 0 && n < 2000; n++) begin
        @(posedge clk);
        #1;
      end
      if (credits == 0) begin
        $display("Error in %0s: pixel source got no credit back from the DUT", cur_name);
        timeouts++;
        aborted = 1'b1;
      end else begin
        i_pix_valid = 1'b1;
        i_pix_data  = pixel_word_t'($urandom);
        @(posedge clk);
        #1;
        i_pix_valid = 1'b0;
        repeat (pause) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  task automatic run_frame(input int te_delay);
    repeat (te_delay) begin
      @(posedge clk);
      #1;
    end
    // Tearing effect with enable low must not start a frame
    i_tearing_effect = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    // Enable without tearing effect must not start one either
    i_tearing_effect = 1'b0;
    i_enable         = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    i_tearing_effect = 1'b1;
    wait_until(WAIT_WRITE, "the command byte");
    // Dropping enable must not cut a running frame short
    i_tearing_effect = 1'b0;
    i_enable         = 1'b0;
    wait_until(WAIT_DONE, "o_frame_done");
    wait_until(WAIT_IDLE, "the last pixel byte");
  endtask

  initial begin
    void'($urandom(32'h6bb1eea8));
    clk              = 1'b0;
    rst              = 1'b1;
    i_enable         = 1'b0;
    i_num_pixels     = '0;
    i_tearing_effect = 1'b0;
    i_pix_valid      = 1'b0;
    i_pix_data       = '0;
    final_check      = 1'b0;
    cur_name         = "reset";
    frames_run       = 0;
    timeouts         = 0;
    aborted          = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    for (row = 0; row < 6 && !aborted; row++) begin
      cur_name     = frame_table[row].name;
      i_num_pixels = PIX_COUNT_W'(frame_table[row].num_pixels);
      fork
        send_words(frame_table[row].num_pixels, frame_table[row].pause);
        run_frame(frame_table[row].te_delay);
      join
      frames_run++;
    end
    final_check = 1'b1;
    @(posedge clk);
    #1;
    final_check = 1'b0;
    $display("Errors: value=%0d other=%0d timeouts=%0d", value_errors, other_errors, timeouts);
    if (value_errors + other_errors + timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
